/* hdl/ieu_settings.svh */
////////////////////////////////////////////////////////////
// Integer execute stage widths
// Data, byte address and register index sizes shared by
// the package, the RTL and the testbench
////////////////////////////////////////////////////////////

`ifndef IEU_SETTINGS_SVH
`define IEU_SETTINGS_SVH

// Data word
`define IEU_DW 32

// Byte address, the low two bits drop for instruction addresses
`define IEU_AW 32

`define IEU_REG_AW 5   // 32 architectural registers

`endif

/* hdl/ieu_pkg.sv */
////////////////////////////////////////////////////////////
// Integer execute stage types
// Data words, instruction addresses, opcodes, access sizes
////////////////////////////////////////////////////////////

`include "ieu_settings.svh"

package ieu_pkg;

   typedef logic [`IEU_DW-1:0]     data_t;
   typedef logic [`IEU_AW-3:0]     pc_t;       // Word address
   typedef logic [`IEU_REG_AW-1:0] reg_idx_t;

   // Decoded operation
   typedef enum logic [3:0] {
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_sll,
      op_srl,
      op_sra,
      op_cmp_eq,
      op_cmp_lt,    // Signed
      op_cmp_ltu,   // Unsigned
      op_load,
      op_store,
      op_jmp_rel,   // Conditional, direction predicted
      op_jmp_far    // Register target, target predicted
   } ieu_op_e;

   // Bytes per access, one-hot as on the data bus
   typedef enum logic [2:0] {
      size_byte = 3'd1,
      size_half = 3'd2,
      size_word = 3'd4
   } mem_size_e;

endpackage

/* hdl/ieu_arith.sv */
////////////////////////////////////////////////////////////
// Arithmetic unit
// Shared adder for add, sub and address, compares and the
// condition flag register
////////////////////////////////////////////////////////////

module ieu_arith (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             commit,
   input  ieu_pkg::ieu_op_e op,
   input  ieu_pkg::data_t   operand_1,
   input  ieu_pkg::data_t   operand_2,
   output ieu_pkg::data_t   sum,
   output logic             cond_flag
);
   import ieu_pkg::*;

   localparam int DW = $bits(data_t);

   logic          subtract;
   logic          is_cmp;
   data_t         addend;
   logic [DW:0]   sum_ext;     // Carry out on top
   logic          borrow;
   logic          equal;
   logic          less_signed;
   logic          cmp_result;

   assign is_cmp   = op inside {op_cmp_eq, op_cmp_lt, op_cmp_ltu};
   assign subtract = (op == op_sub) | is_cmp;
   assign addend   = subtract ? ~operand_2 : operand_2;
   assign sum_ext  = {1'b0, operand_1} + {1'b0, addend} + {{DW{1'b0}}, subtract};
   assign sum      = sum_ext[DW-1:0];

   assign borrow = ~sum_ext[DW];   // No carry out of a - b means a < b
   assign equal  = (sum_ext[DW-1:0] == '0);
   // Sign bits differ, so the negative one is smaller
   assign less_signed = (operand_1[DW-1] != operand_2[DW-1]) ? operand_1[DW-1] :
                                                                sum_ext[DW-1];

   always_comb begin
      case (op)
         op_cmp_eq: cmp_result = equal;
         op_cmp_lt: cmp_result = less_signed;
         default:   cmp_result = borrow;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cond_flag <= 1'b0;
      end else if (commit && is_cmp) begin
         cond_flag <= cmp_result;
      end
   end

endmodule

/* hdl/ieu_logic.sv */
////////////////////////////////////////////////////////////
// Logic unit
// Bitwise and/or/xor and a single right barrel shifter that
// serves all three shifts
////////////////////////////////////////////////////////////

module ieu_logic (
   input  ieu_pkg::ieu_op_e op,
   input  ieu_pkg::data_t   operand_1,
   input  ieu_pkg::data_t   operand_2,
   output ieu_pkg::data_t   result
);
   import ieu_pkg::*;

   localparam int DW  = $bits(data_t);
   localparam int SHW = $clog2(DW);

   function automatic data_t bit_reverse(input data_t d);
      data_t r;
      for (int i = 0; i < DW; i++) begin
         r[i] = d[DW-1-i];
      end
      return r;
   endfunction

   logic [SHW-1:0] shamt;
   logic           fill;
   data_t          stage [0:SHW];

   assign shamt = operand_2[SHW-1:0];
   assign fill  = (op == op_sra) & operand_1[DW-1];   // Sign fill for sra only

   // Left shift runs through the right shifter on reversed bits
   assign stage[0] = (op == op_sll) ? bit_reverse(operand_1) : operand_1;

   for (genvar i = 0; i < SHW; i++) begin : g_stage
      assign stage[i+1] = shamt[i] ? {{(2**i){fill}}, stage[i][DW-1:2**i]} : stage[i];
   end

   always_comb begin
      case (op)
         op_and:         result = operand_1 & operand_2;
         op_or:          result = operand_1 | operand_2;
         op_xor:         result = operand_1 ^ operand_2;
         op_sll:         result = bit_reverse(stage[SHW]);
         op_srl, op_sra: result = stage[SHW];
         default:        result = '0;
      endcase
   end

endmodule

/* hdl/ieu_lsu.sv */
////////////////////////////////////////////////////////////
// Load/store sequencer
// Holds one request, issues it on the data bus command
// phase and returns the extended load data for write-back
////////////////////////////////////////////////////////////

`include "ieu_settings.svh"

module ieu_lsu (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 start,
   input  logic                 is_store,
   input  ieu_pkg::data_t       addr,
   input  ieu_pkg::data_t       store_data,
   input  ieu_pkg::mem_size_e   size,
   input  logic                 sign_ext,
   input  logic                 wb_regf,
   input  ieu_pkg::reg_idx_t    wb_reg_addr,
   output logic                 busy,
   input  logic                 dbus_cmd_ready,
   output logic                 dbus_cmd_valid,
   output logic [`IEU_AW-1:0]   dbus_cmd_addr,
   output ieu_pkg::mem_size_e   dbus_cmd_size,
   output logic                 dbus_cmd_we,
   output ieu_pkg::data_t       dbus_din,
   output logic                 dbus_ready,
   input  logic                 dbus_valid,
   input  ieu_pkg::data_t       dbus_dout,
   output logic                 load_we,
   output ieu_pkg::reg_idx_t    load_reg_addr,
   output ieu_pkg::data_t       load_data
);
   import ieu_pkg::*;

   localparam int DW = $bits(data_t);

   // Low byte, half or word, filled with zeros or the top kept bit
   function automatic data_t extend(input data_t d, input mem_size_e sz, input logic sgn);
      data_t r;
      case (sz)
         size_byte: r = {{(DW-8){sgn & d[7]}}, d[7:0]};
         size_half: r = {{(DW-16){sgn & d[15]}}, d[15:0]};
         default:   r = d;
      endcase
      return r;
   endfunction

   typedef enum logic [1:0] {s_idle, s_cmd, s_resp} state_e;

   state_e              state;
   logic [`IEU_AW-1:0]  addr_r;
   data_t               data_r;
   mem_size_e           size_r;
   logic                store_r;
   logic                sign_ext_r;
   logic                wb_regf_r;
   reg_idx_t            reg_addr_r;
   logic                cmd_done;
   logic                resp_done;

   assign cmd_done  = dbus_cmd_valid & dbus_cmd_ready;
   assign resp_done = dbus_valid & dbus_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= s_idle;
      end else begin
         case (state)
            s_idle: begin
               if (start) begin
                  state <= s_cmd;
               end
            end
            s_cmd: begin
               if (cmd_done) begin
                  state <= store_r ? s_idle : s_resp;   // Stores need no response
               end
            end
            default: begin
               if (resp_done) begin
                  state <= s_idle;
               end
            end
         endcase
      end
   end

   // Request fields, held stable through back-pressure
   always_ff @(posedge clk) begin
      if (start) begin
         addr_r     <= addr[`IEU_AW-1:0];
         data_r     <= extend(store_data, size, 1'b0);
         size_r     <= size;
         store_r    <= is_store;
         sign_ext_r <= sign_ext;
         wb_regf_r  <= wb_regf;
         reg_addr_r <= wb_reg_addr;
      end
   end

   assign busy           = (state != s_idle);
   assign dbus_cmd_valid = (state == s_cmd);
   assign dbus_cmd_addr  = addr_r;
   assign dbus_cmd_size  = size_r;
   assign dbus_cmd_we    = store_r;
   assign dbus_din       = data_r;
   assign dbus_ready     = (state == s_resp);

   assign load_we       = resp_done & wb_regf_r;
   assign load_reg_addr = reg_addr_r;
   assign load_data     = extend(dbus_dout, size_r, sign_ext_r);

endmodule

/* hdl/ieu_branch_check.sv */
////////////////////////////////////////////////////////////
// Branch speculation check
// Compares predictions at commit and holds the flush
// request with its target until acknowledged
////////////////////////////////////////////////////////////

module ieu_branch_check (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             commit,
   input  ieu_pkg::ieu_op_e op,
   input  logic             cond_flag,
   input  logic             specul_bcc,
   input  ieu_pkg::pc_t     specul_tgt,
   input  ieu_pkg::data_t   operand_1,
   input  logic             specul_flush_ack,
   output logic             specul_flush,
   output ieu_pkg::pc_t     ifu_flush_jmp_tgt,
   output logic             flush_hold,
   output logic             bpu_wb,
   output logic             bpu_wb_jmprel,
   output logic             bpu_wb_hit
);
   import ieu_pkg::*;

   localparam int PW = $bits(pc_t);

   logic  is_rel;
   logic  is_far;
   pc_t   far_tgt;
   logic  mispredict;
   logic  flush_req;
   pc_t   req_tgt;
   logic  flush_r;
   pc_t   tgt_r;

   assign is_rel  = (op == op_jmp_rel);
   assign is_far  = (op == op_jmp_far);
   assign far_tgt = operand_1[PW+1:2];   // Word address of the register target

   assign mispredict = (is_rel & (specul_bcc != cond_flag)) |
                       (is_far & (far_tgt != specul_tgt));
   assign flush_req  = commit & mispredict;
   assign req_tgt    = is_far ? far_tgt : specul_tgt;   // Taken or fall-through from decode

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flush_r <= 1'b0;
      end else begin
         flush_r <= (flush_r | flush_req) & ~specul_flush_ack;
      end
   end

   always_ff @(posedge clk) begin
      if (flush_req) begin
         tgt_r <= req_tgt;
      end
   end

   // New request passes straight through in its commit cycle
   assign specul_flush      = flush_r | flush_req;
   assign ifu_flush_jmp_tgt = flush_r ? tgt_r : req_tgt;
   assign flush_hold        = flush_r;

   assign bpu_wb        = commit & (is_rel | is_far);
   assign bpu_wb_jmprel = is_rel;
   assign bpu_wb_hit    = ~flush_req;

endmodule

/* hdl/ieu_top.sv */
////////////////////////////////////////////////////////////
// Integer execute stage
// Commit control, write-back selection and the arithmetic,
// logic, load/store and branch check units
////////////////////////////////////////////////////////////

`include "ieu_settings.svh"

module ieu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  ieu_pkg::ieu_op_e     op,
   input  ieu_pkg::data_t       operand_1,
   input  ieu_pkg::data_t       operand_2,
   input  ieu_pkg::data_t       operand_3,
   input  logic                 sign_ext,
   input  ieu_pkg::mem_size_e   mem_size,
   input  logic                 wb_regf,
   input  ieu_pkg::reg_idx_t    wb_reg_addr,
   input  ieu_pkg::pc_t         insn_pc,
   input  logic                 link,
   input  logic                 specul_bcc,
   input  ieu_pkg::pc_t         specul_tgt,
   input  logic                 dbus_cmd_ready,
   output logic                 dbus_cmd_valid,
   output logic [`IEU_AW-1:0]   dbus_cmd_addr,
   output ieu_pkg::mem_size_e   dbus_cmd_size,
   output logic                 dbus_cmd_we,
   output ieu_pkg::data_t       dbus_din,
   output logic                 dbus_ready,
   input  logic                 dbus_valid,
   input  ieu_pkg::data_t       dbus_dout,
   output logic                 regf_we,
   output ieu_pkg::reg_idx_t    regf_din_addr,
   output ieu_pkg::data_t       regf_din,
   output logic                 specul_flush,
   input  logic                 specul_flush_ack,
   output ieu_pkg::pc_t         ifu_flush_jmp_tgt,
   output logic                 bpu_wb,
   output logic                 bpu_wb_jmprel,
   output ieu_pkg::pc_t         bpu_wb_insn_pc,
   output logic                 bpu_wb_hit
);
   import ieu_pkg::*;

   logic      commit;
   logic      cond_flag;
   logic      flush_hold;
   logic      lsu_busy;
   logic      lsu_start;
   data_t     sum;
   data_t     logic_result;
   data_t     link_addr;
   pc_t       pc_next;
   logic      load_we;
   reg_idx_t  load_reg_addr;
   data_t     load_data;
   logic      has_result;
   data_t     exec_result;

   assign in_ready  = ~flush_hold & ~lsu_busy;
   assign commit    = in_valid & in_ready;
   assign lsu_start = commit & (op inside {op_load, op_store});

   assign pc_next   = insn_pc + 1'b1;
   assign link_addr = data_t'({pc_next, 2'b00});   // Byte address of the next instruction

   always_comb begin
      case (op)
         op_add, op_sub: begin
            has_result  = 1'b1;
            exec_result = sum;
         end
         op_and, op_or, op_xor, op_sll, op_srl, op_sra: begin
            has_result  = 1'b1;
            exec_result = logic_result;
         end
         op_jmp_rel, op_jmp_far: begin
            has_result  = link;
            exec_result = link_addr;
         end
         default: begin   // Compares, loads and stores
            has_result  = 1'b0;
            exec_result = '0;
         end
      endcase
   end

   // Sequencer busy keeps commits away from a load write-back
   assign regf_we       = load_we | (commit & wb_regf & has_result);
   assign regf_din_addr = load_we ? load_reg_addr : wb_reg_addr;
   assign regf_din      = load_we ? load_data : exec_result;

   assign bpu_wb_insn_pc = insn_pc;

   ieu_arith i_arith (
      .clk       (clk),
      .rst_n     (rst_n),
      .commit    (commit),
      .op        (op),
      .operand_1 (operand_1),
      .operand_2 (operand_2),
      .sum       (sum),
      .cond_flag (cond_flag)
   );

   ieu_logic i_logic (
      .op        (op),
      .operand_1 (operand_1),
      .operand_2 (operand_2),
      .result    (logic_result)
   );

   ieu_lsu i_lsu (
      .clk            (clk),
      .rst_n          (rst_n),
      .start          (lsu_start),
      .is_store       (op == op_store),
      .addr           (sum),
      .store_data     (operand_3),
      .size           (mem_size),
      .sign_ext       (sign_ext),
      .wb_regf        (wb_regf),
      .wb_reg_addr    (wb_reg_addr),
      .busy           (lsu_busy),
      .dbus_cmd_ready (dbus_cmd_ready),
      .dbus_cmd_valid (dbus_cmd_valid),
      .dbus_cmd_addr  (dbus_cmd_addr),
      .dbus_cmd_size  (dbus_cmd_size),
      .dbus_cmd_we    (dbus_cmd_we),
      .dbus_din       (dbus_din),
      .dbus_ready     (dbus_ready),
      .dbus_valid     (dbus_valid),
      .dbus_dout      (dbus_dout),
      .load_we        (load_we),
      .load_reg_addr  (load_reg_addr),
      .load_data      (load_data)
   );

   ieu_branch_check i_branch_check (
      .clk               (clk),
      .rst_n             (rst_n),
      .commit            (commit),
      .op                (op),
      .cond_flag         (cond_flag),
      .specul_bcc        (specul_bcc),
      .specul_tgt        (specul_tgt),
      .operand_1         (operand_1),
      .specul_flush_ack  (specul_flush_ack),
      .specul_flush      (specul_flush),
      .ifu_flush_jmp_tgt (ifu_flush_jmp_tgt),
      .flush_hold        (flush_hold),
      .bpu_wb            (bpu_wb),
      .bpu_wb_jmprel     (bpu_wb_jmprel),
      .bpu_wb_hit        (bpu_wb_hit)
   );

endmodule

/* dv/ieu_scoreboard.sv */
////////////////////////////////////////////////////////////
// Execute stage scoreboard
// Tracks flag, flush and sequencer state from the inputs and
// compares every DUT output once per cycle
////////////////////////////////////////////////////////////

`include "ieu_settings.svh"

module ieu_scoreboard (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  logic                 in_ready,
   input  ieu_pkg::ieu_op_e     op,
   input  ieu_pkg::data_t       operand_1,
   input  ieu_pkg::data_t       operand_2,
   input  ieu_pkg::data_t       operand_3,
   input  logic                 sign_ext,
   input  ieu_pkg::mem_size_e   mem_size,
   input  logic                 wb_regf,
   input  ieu_pkg::reg_idx_t    wb_reg_addr,
   input  ieu_pkg::pc_t         insn_pc,
   input  logic                 link,
   input  logic                 specul_bcc,
   input  ieu_pkg::pc_t         specul_tgt,
   input  logic                 dbus_cmd_ready,
   input  logic                 dbus_cmd_valid,
   input  logic [`IEU_AW-1:0]   dbus_cmd_addr,
   input  ieu_pkg::mem_size_e   dbus_cmd_size,
   input  logic                 dbus_cmd_we,
   input  ieu_pkg::data_t       dbus_din,
   input  logic                 dbus_ready,
   input  logic                 dbus_valid,
   input  ieu_pkg::data_t       dbus_dout,
   input  logic                 regf_we,
   input  ieu_pkg::reg_idx_t    regf_din_addr,
   input  ieu_pkg::data_t       regf_din,
   input  logic                 specul_flush,
   input  logic                 specul_flush_ack,
   input  ieu_pkg::pc_t         ifu_flush_jmp_tgt,
   input  logic                 bpu_wb,
   input  logic                 bpu_wb_jmprel,
   input  ieu_pkg::pc_t         bpu_wb_insn_pc,
   input  logic                 bpu_wb_hit,
   output int                   errors,
   output int                   checks
);
   import ieu_pkg::*;

   logic       exp_flag;
   logic       exp_hold;
   pc_t        exp_tgt;
   int         lsu_state;    // 0 idle, 1 command, 2 response
   data_t      cmd_addr;
   mem_size_e  cmd_size;
   logic       cmd_we;
   data_t      cmd_data;
   logic       ld_sign;
   logic       ld_wb;
   reg_idx_t   ld_reg;
   logic [7:0] ref_mem [data_t];   // Bytes written by committed stores

   initial begin
      errors = 0;
      checks = 0;
   end

   // Expected write-back value, returns whether the op writes at all
   function automatic logic ref_result(input ieu_op_e o, input data_t a, input data_t b,
                                       input pc_t pc, input logic lnk, output data_t value);
      logic has;
      has = 1'b1;
      case (o)
         op_add:   value = a + b;
         op_sub:   value = a - b;
         op_and:   value = a & b;
         op_or:    value = a | b;
         op_xor:   value = a ^ b;
         op_sll:   value = a << b[4:0];
         op_srl:   value = a >> b[4:0];
         op_sra:   value = data_t'($signed(a) >>> b[4:0]);
         op_jmp_rel, op_jmp_far: begin
            value = (data_t'(pc) + 1) << 2;   // Byte address after the jump
            has   = lnk;
         end
         default: begin
            value = '0;
            has   = 1'b0;
         end
      endcase
      return has;
   endfunction

   function automatic logic ref_compare(input ieu_op_e o, input data_t a, input data_t b);
      case (o)
         op_cmp_eq: return a == b;
         op_cmp_lt: return $signed(a) < $signed(b);
         default:   return a < b;
      endcase
   endfunction

   function automatic data_t ref_extend(input data_t d, input mem_size_e sz, input logic sgn);
      case (sz)
         size_byte: return sgn ? data_t'($signed(d[7:0])) : data_t'(d[7:0]);
         size_half: return sgn ? data_t'($signed(d[15:0])) : data_t'(d[15:0]);
         default:   return d;
      endcase
   endfunction

   function automatic data_t size_mask(input mem_size_e sz);
      return (sz == size_word) ? '1 : (data_t'(1) << (8 * int'(sz))) - 1;
   endfunction

   task automatic check_value(input string what, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Model memory must return what earlier stores wrote
   task automatic check_load_bytes();
      for (int k = 0; k < int'(cmd_size); k++) begin
         if (ref_mem.exists(cmd_addr + k)) begin
            check_value("load memory byte", dbus_dout[8*k +: 8], ref_mem[cmd_addr + k]);
         end
      end
   endtask

   always @(negedge clk) begin : compare_cycle
      logic     exp_ready;
      logic     commit;
      logic     has;
      data_t    value;
      logic     is_branch;
      logic     mispredict;
      pc_t      req_tgt;
      logic     exp_we;
      reg_idx_t exp_addr;
      data_t    exp_din;
      if (!rst_n) begin
         exp_flag  = 1'b0;
         exp_hold  = 1'b0;
         lsu_state = 0;
      end else begin
         exp_ready = !exp_hold && (lsu_state == 0);
         commit    = in_valid && exp_ready;
         check_value("in_ready", in_ready, exp_ready);
         check_value("dbus_cmd_valid", dbus_cmd_valid, lsu_state == 1);
         check_value("dbus_ready", dbus_ready, lsu_state == 2);
         if (lsu_state == 1) begin
            check_value("dbus_cmd_addr", dbus_cmd_addr, cmd_addr);
            check_value("dbus_cmd_size", dbus_cmd_size, cmd_size);
            check_value("dbus_cmd_we", dbus_cmd_we, cmd_we);
            check_value("dbus_din", dbus_din, cmd_data);
         end

         has = ref_result(op, operand_1, operand_2, insn_pc, link, value);
         if (lsu_state == 2 && dbus_valid) begin
            exp_we   = ld_wb;
            exp_addr = ld_reg;
            exp_din  = ref_extend(dbus_dout, cmd_size, ld_sign);
            check_load_bytes();
         end else begin
            exp_we   = commit && wb_regf && has;
            exp_addr = wb_reg_addr;
            exp_din  = value;
         end
         check_value("regf_we", regf_we, exp_we);
         if (exp_we) begin
            check_value("regf_din_addr", regf_din_addr, exp_addr);
            check_value("regf_din", regf_din, exp_din);
         end

         is_branch  = commit && (op == op_jmp_rel || op == op_jmp_far);
         req_tgt    = (op == op_jmp_far) ? pc_t'(operand_1 >> 2) : specul_tgt;
         mispredict = is_branch && ((op == op_jmp_rel) ? (specul_bcc != exp_flag)
                                                       : (req_tgt != specul_tgt));
         check_value("bpu_wb", bpu_wb, is_branch);
         if (is_branch) begin
            check_value("bpu_wb_hit", bpu_wb_hit, !mispredict);
            check_value("bpu_wb_jmprel", bpu_wb_jmprel, op == op_jmp_rel);
            check_value("bpu_wb_insn_pc", bpu_wb_insn_pc, insn_pc);
         end
         check_value("specul_flush", specul_flush, exp_hold || mispredict);
         if (exp_hold || mispredict) begin
            check_value("ifu_flush_jmp_tgt", ifu_flush_jmp_tgt, exp_hold ? exp_tgt : req_tgt);
         end

         // State for the next cycle
         if (mispredict) begin
            exp_tgt = req_tgt;
         end
         exp_hold = (exp_hold || mispredict) && !specul_flush_ack;
         if (commit && op inside {op_cmp_eq, op_cmp_lt, op_cmp_ltu}) begin
            exp_flag = ref_compare(op, operand_1, operand_2);
         end
         case (lsu_state)
            0: begin
               if (commit && (op == op_load || op == op_store)) begin
                  cmd_addr  = operand_1 + operand_2;
                  cmd_size  = mem_size;
                  cmd_we    = (op == op_store);
                  cmd_data  = operand_3 & size_mask(mem_size);
                  ld_sign   = sign_ext;
                  ld_wb     = wb_regf;
                  ld_reg    = wb_reg_addr;
                  lsu_state = 1;
               end
            end
            1: begin
               if (dbus_cmd_ready) begin
                  if (cmd_we) begin
                     for (int k = 0; k < int'(cmd_size); k++) begin
                        ref_mem[cmd_addr + k] = cmd_data[8*k +: 8];
                     end
                  end
                  lsu_state = cmd_we ? 0 : 2;
               end
            end
            default: begin
               if (dbus_valid) begin
                  lsu_state = 0;
               end
            end
         endcase
      end
   end

endmodule

/* dv/ieu_checker.sv */
////////////////////////////////////////////////////////////
// Execute stage protocol assertions
// Data bus command stability, flush hold and commit blocking
////////////////////////////////////////////////////////////

`include "ieu_settings.svh"

module ieu_checker (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_ready,
   input  logic                 dbus_cmd_valid,
   input  logic                 dbus_cmd_ready,
   input  logic [`IEU_AW-1:0]   dbus_cmd_addr,
   input  ieu_pkg::mem_size_e   dbus_cmd_size,
   input  logic                 dbus_cmd_we,
   input  ieu_pkg::data_t       dbus_din,
   input  logic                 dbus_ready,
   input  logic                 specul_flush,
   input  logic                 specul_flush_ack
);
   import ieu_pkg::*;

   int fail_count = 0;   // Read by the testbench top

   // Command held under back-pressure
   cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_cmd_valid && !dbus_cmd_ready |=> dbus_cmd_valid && $stable(dbus_cmd_addr) &&
         $stable(dbus_cmd_size) && $stable(dbus_cmd_we) && $stable(dbus_din))
   else begin
      fail_count++;
      $error("Data bus command changed or dropped before ready");
   end

   flush_held: assert property (@(posedge clk) disable iff (!rst_n)
      specul_flush && !specul_flush_ack |=> specul_flush)
   else begin
      fail_count++;
      $error("Flush request dropped before acknowledge");
   end

   // Sequencer busy blocks new instructions
   ready_blocked: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_cmd_valid || dbus_ready |-> !in_ready)
   else begin
      fail_count++;
      $error("Input ready while a data bus access is open");
   end

endmodule

bind ieu_top ieu_checker i_checker (.*);

/* dv/ieu_tb.sv */
////////////////////////////////////////////////////////////
// Execute stage testbench
// Random instruction stimulus, data bus memory model with
// random latency, flush acknowledge and run control
////////////////////////////////////////////////////////////

`include "ieu_settings.svh"

module ieu_tb;
   import ieu_pkg::*;

   localparam int CLK_PERIOD = 4;
   localparam int N_ALU      = 60;
   localparam int N_BRANCH   = 30;   // Each one a compare and a relative jump
   localparam int N_FAR      = 12;
   localparam int N_STORE    = 24;
   localparam int N_LOAD     = 40;
   localparam int N_TOTAL    = N_ALU + 2 * N_BRANCH + N_FAR + N_STORE + N_LOAD;

   logic clk;
   logic rst_n;
   logic in_valid;
   logic in_ready;
   ieu_op_e op;
   data_t operand_1;
   data_t operand_2;
   data_t operand_3;
   logic sign_ext;
   mem_size_e mem_size;
   logic wb_regf;
   reg_idx_t wb_reg_addr;
   pc_t insn_pc;
   logic link;
   logic specul_bcc;
   pc_t specul_tgt;
   logic dbus_cmd_ready;
   logic dbus_cmd_valid;
   logic [`IEU_AW-1:0] dbus_cmd_addr;
   mem_size_e dbus_cmd_size;
   logic dbus_cmd_we;
   data_t dbus_din;
   logic dbus_ready;
   logic dbus_valid;
   data_t dbus_dout;
   logic regf_we;
   reg_idx_t regf_din_addr;
   data_t regf_din;
   logic specul_flush;
   logic specul_flush_ack;
   pc_t ifu_flush_jmp_tgt;
   logic bpu_wb;
   logic bpu_wb_jmprel;
   pc_t bpu_wb_insn_pc;
   logic bpu_wb_hit;
   int sb_errors;
   int sb_checks;
   logic [7:0] mem [0:1023];

   ieu_top i_dut (.*);

   ieu_scoreboard i_scoreboard (.*, .errors(sb_errors), .checks(sb_checks));

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic data_t read_word(input logic [9:0] a);
      return {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
   endfunction

   task automatic randomize_fields();
      operand_1   = $urandom;
      operand_2   = $urandom;
      operand_3   = $urandom;
      sign_ext    = $urandom_range(1);
      mem_size    = size_word;
      wb_regf     = $urandom_range(1);
      wb_reg_addr = reg_idx_t'($urandom);
      insn_pc     = pc_t'($urandom);
      link        = $urandom_range(1);
      specul_bcc  = $urandom_range(1);
      specul_tgt  = pc_t'($urandom);
   endtask

   // Aligned address in [lo, hi] split over both operands
   task automatic set_address(input int lo, input int hi);
      data_t addr;
      mem_size = mem_size_e'(1 << $urandom_range(2));
      addr      = data_t'($urandom_range(hi, lo)) & ~(data_t'(mem_size) - 1);
      operand_1 = $urandom_range(addr);
      operand_2 = addr - operand_1;
   endtask

   // Hold in_valid until the DUT takes the instruction
   task automatic send_insn();
      in_valid = 1'b1;
      @(negedge clk);
      while (!in_ready) @(negedge clk);
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   // Command phase and then the response for loads
   always begin : bus_model
      logic [9:0] a;
      logic       we;
      @(posedge clk);
      #1;
      if (rst_n && dbus_cmd_valid) begin
         repeat ($urandom_range(3)) begin
            @(posedge clk);
            #1;
         end
         dbus_cmd_ready = 1'b1;
         a  = dbus_cmd_addr[9:0];
         we = dbus_cmd_we;
         if (we) begin
            for (int k = 0; k < int'(dbus_cmd_size); k++) begin
               mem[a + k] = dbus_din[8*k +: 8];
            end
         end
         @(posedge clk);
         #1;
         dbus_cmd_ready = 1'b0;
         if (!we) begin
            repeat ($urandom_range(3)) begin
               @(posedge clk);
               #1;
            end
            dbus_valid = 1'b1;
            dbus_dout  = read_word(a);
            @(posedge clk);
            #1;
            dbus_valid = 1'b0;
            dbus_dout  = $urandom;   // Junk outside the response
         end
      end
   end

   always begin : flush_ack_model
      @(negedge clk);
      if (rst_n && specul_flush) begin
         repeat ($urandom_range(3)) @(posedge clk);
         @(posedge clk);
         #1;
         specul_flush_ack = 1'b1;
         @(posedge clk);
         #1;
         specul_flush_ack = 1'b0;
      end
   end

   initial begin : watchdog
      #(N_TOTAL * 20 * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d cycles", N_TOTAL * 20);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin : stimulus
      void'($urandom(32'h684e));
      clk              = 1'b0;
      rst_n            = 1'b0;
      in_valid         = 1'b0;
      op               = op_add;
      dbus_cmd_ready   = 1'b0;
      dbus_valid       = 1'b0;
      dbus_dout        = '0;
      specul_flush_ack = 1'b0;
      randomize_fields();
      for (int i = 0; i < 1024; i++) begin
         mem[i] = 8'((i * 13) ^ (i >> 5));
      end
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < N_ALU; i++) begin
         randomize_fields();
         op = ieu_op_e'($urandom_range(7));   // add through sra
         send_insn();
      end
      for (int i = 0; i < N_BRANCH; i++) begin
         randomize_fields();
         op = ieu_op_e'($urandom_range(10, 8));
         if ($urandom_range(3) == 0) begin
            operand_2 = operand_1;
         end
         send_insn();
         randomize_fields();
         op = op_jmp_rel;
         send_insn();
      end
      for (int i = 0; i < N_FAR; i++) begin
         randomize_fields();
         op = op_jmp_far;
         if ($urandom_range(1)) begin
            specul_tgt = pc_t'(operand_1 >> 2);
         end
         send_insn();
      end
      for (int i = 0; i < N_STORE; i++) begin
         randomize_fields();
         op = op_store;
         set_address(0, 255);
         send_insn();
      end
      for (int i = 0; i < N_LOAD; i++) begin
         randomize_fields();
         op = op_load;
         set_address(0, 511);   // Half of them over stored bytes
         send_insn();
      end

      @(negedge clk);
      while (!in_ready) @(negedge clk);
      @(negedge clk);
      #1;
      $display("Checks: %0d, scoreboard errors: %0d, assertion failures: %0d",
               sb_checks, sb_errors, i_dut.i_checker.fail_count);
      if (sb_errors == 0 && i_dut.i_checker.fail_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+hdl
hdl/ieu_pkg.sv
hdl/ieu_arith.sv
hdl/ieu_logic.sv
hdl/ieu_lsu.sv
hdl/ieu_branch_check.sv
hdl/ieu_top.sv
dv/ieu_scoreboard.sv
dv/ieu_checker.sv
dv/ieu_tb.sv

/* Bender.yml */
package:
  name: ieu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ieu_pkg.sv
      - hdl/ieu_arith.sv
      - hdl/ieu_logic.sv
      - hdl/ieu_lsu.sv
      - hdl/ieu_branch_check.sv
      - hdl/ieu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/ieu_scoreboard.sv
      - dv/ieu_checker.sv
      - dv/ieu_tb.sv
